/* bench/list_memory_model.sv */
module list_memory_model #(
   parameter int nodes     = 32,
   parameter int max_delay = 20
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                rq_vld,
   input  logic [search_list_pkg::addr_w-1:0]  rq_address,
   output logic                                rq_afull,
   output logic                                rs_write_en,
   output logic [search_list_pkg::data_w-1:0]  rs_data,
   input  logic                                rs_afull
);

   // dim keys are key_base plus the node's position in the chain layout
   localparam logic [31:0] key_base = 32'hA000_0000;

   // six chains, 32 positions in total
   int chain_start [6] = '{0, 8, 16, 22, 27, 30};
   int chain_len   [6] = '{8, 8, 6, 5, 3, 2};
   int heads       [6];

   logic [search_list_pkg::data_w-1:0] words [2*nodes];
   logic [search_list_pkg::addr_w-1:0] addr_q [$];
   int ready_q [$];
   int cycle;
   int last_ready;
   int ready;
   int pending;

   // scatter chain positions over the node slots
   function automatic int slot(input int k);
      return (k * 13 + 5) % nodes;
   endfunction

   initial
   begin
      int k;
      rq_afull    = 1'b0;
      rs_write_en = 1'b0;
      rs_data     = '0;
      cycle       = 0;
      last_ready  = 0;
      pending     = 0;
      for (int c = 0; c < 6; c++)
      begin
         heads[c] = slot(chain_start[c]);
         for (int i = 0; i < chain_len[c]; i++)
         begin
            k = chain_start[c] + i;
            // low half differs from any fact, only the key matters
            words[2*slot(k)]   = {key_base + 32'(k), 32'(k * 7919)};
            words[2*slot(k)+1] = (i == chain_len[c] - 1) ?
                                 search_list_pkg::null_ptr : 64'(slot(k + 1));
         end
      end
   end

   always @(posedge clk)
   begin
      if (rst)
      begin
         addr_q.delete();
         ready_q.delete();
         last_ready  = 0;
         rs_write_en <= 1'b0;
         rq_afull    <= 1'b0;
      end
      else
      begin
         if (rq_vld)
         begin
            // random latency, but a lane never reorders
            ready = cycle + $urandom_range(1, max_delay);
            if (ready < last_ready)
               ready = last_ready;
            last_ready = ready;
            addr_q.push_back(rq_address);
            ready_q.push_back(ready);
         end
         // hold responses while the DUT queue is almost full
         if (addr_q.size() != 0 && ready_q[0] <= cycle && !rs_afull)
         begin
            rs_write_en <= 1'b1;
            rs_data     <= words[addr_q[0]];
            void'(addr_q.pop_front());
            void'(ready_q.pop_front());
         end
         else
            rs_write_en <= 1'b0;
         rq_afull <= ($urandom_range(0, 7) == 0);
      end
      pending = addr_q.size();
      cycle   = cycle + 1;
   end

endmodule

/* bench/search_list_tb.sv */
module search_list_tb;

   localparam int job_count = 40;
   // jobs x longest chain x worst latency, plus slack
   localparam int timeout_cycles = job_count * 8 * 20 + 2000;

   logic                               clk;
   logic                               rst;
   logic                               new_job_empty;
   search_list_pkg::job_t              new_job;
   logic                               new_job_read_en;
   logic                               rq0_vld;
   logic [search_list_pkg::addr_w-1:0] rq0_address;
   logic                               rq0_afull;
   logic                               rq1_vld;
   logic [search_list_pkg::addr_w-1:0] rq1_address;
   logic                               rq1_afull;
   logic                               rs0_write_en;
   logic [search_list_pkg::data_w-1:0] rs0_data;
   logic                               rs0_afull;
   logic                               rs1_write_en;
   logic [search_list_pkg::data_w-1:0] rs1_data;
   logic                               rs1_afull;
   logic                               output_empty;
   logic                               output_read_en;
   search_list_pkg::match_t            output_data;
   logic                               done;

   search_list_pkg::job_t   jobs [$];
   search_list_pkg::match_t expected [$];
   int errors;
   int reads;
   int jobs_left;
   int stall_left;
   int cycles;

   search_list #(.fifo_depth(16), .afull_level(12), .done_hold(4)) dut0 (
      .clk(clk), .rst(rst), .new_job_empty(new_job_empty), .new_job(new_job),
      .new_job_read_en(new_job_read_en), .rq0_vld(rq0_vld), .rq0_address(rq0_address),
      .rq0_afull(rq0_afull), .rq1_vld(rq1_vld), .rq1_address(rq1_address),
      .rq1_afull(rq1_afull), .rs0_write_en(rs0_write_en), .rs0_data(rs0_data),
      .rs0_afull(rs0_afull), .rs1_write_en(rs1_write_en), .rs1_data(rs1_data),
      .rs1_afull(rs1_afull), .output_empty(output_empty), .output_read_en(output_read_en),
      .output_data(output_data), .done(done));

   // lane 0 answers dim words, lane 1 next pointers
   list_memory_model mem_lane0 (
      .clk(clk), .rst(rst), .rq_vld(rq0_vld), .rq_address(rq0_address),
      .rq_afull(rq0_afull), .rs_write_en(rs0_write_en), .rs_data(rs0_data),
      .rs_afull(rs0_afull));

   list_memory_model mem_lane1 (
      .clk(clk), .rst(rst), .rq_vld(rq1_vld), .rq_address(rq1_address),
      .rq_afull(rq1_afull), .rs_write_en(rs1_write_en), .rs_data(rs1_data),
      .rs_afull(rs1_afull));

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // walk the chain, first node with an equal key is the only hit
   task automatic add_expected(input search_list_pkg::job_t job);
      logic [63:0] p;
      logic [63:0] dim;
      logic [63:0] nxt;
      bit searching;
      search_list_pkg::match_t pair;
      p = job.ptr;
      searching = (p != search_list_pkg::null_ptr);
      while (searching)
      begin
         dim = mem_lane0.words[2*p];
         nxt = mem_lane0.words[2*p+1];
         if (dim[search_list_pkg::key_hi:search_list_pkg::key_lo] ==
             job.fact_value[search_list_pkg::key_hi:search_list_pkg::key_lo])
         begin
            pair.dim_value  = dim;
            pair.fact_value = job.fact_value;
            expected.push_back(pair);
            searching = 1'b0;
         end
         else if (nxt == search_list_pkg::null_ptr)
            searching = 1'b0;
         else
            p = nxt;
      end
   endtask

   // depth equal to chain length gives a key found in no node of that chain
   task automatic build_jobs;
      search_list_pkg::job_t job;
      int c;
      int d;
      for (int j = 0; j < job_count; j++)
      begin
         c = $urandom_range(0, 5);
         d = $urandom_range(0, mem_lane0.chain_len[c]);
         job.fact_value = {mem_lane0.key_base + 32'(mem_lane0.chain_start[c] + d),
                           32'($urandom())};
         job.ptr = (j % 7 == 3) ? search_list_pkg::null_ptr : 64'(mem_lane0.heads[c]);
         jobs.push_back(job);
         add_expected(job);
      end
      jobs_left = jobs.size();
   endtask

   task automatic check_pair(input search_list_pkg::match_t pair);
      int found;
      search_list_pkg::match_t closest;
      found   = -1;
      closest = '0;
      for (int i = 0; i < expected.size() && found < 0; i++)
      begin
         if (expected[i] == pair)
            found = i;
         else if (expected[i].fact_value == pair.fact_value)
            closest = expected[i];
      end
      assert (found >= 0)
      else
      begin
         errors++;
         $display("ERROR match: expected %h actual %h", closest, pair);
      end
      if (found >= 0)
         expected.delete(found);
      reads++;
   endtask

   task automatic finish_run;
      $display("errors: %0d, pairs read: %0d, pairs missing: %0d",
               errors, reads, expected.size());
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   endtask

   // source queue, head consumed in the cycle read_en was high
   always @(posedge clk)
   begin
      if (rst)
         new_job_empty <= 1'b1;
      else
      begin
         if (new_job_read_en && jobs.size() != 0)
         begin
            void'(jobs.pop_front());
            jobs_left = jobs.size();
         end
         new_job_empty <= (jobs.size() == 0);
         new_job       <= (jobs.size() != 0) ? jobs[0] : '0;
      end
   end

   // drain every other cycle, with random stretches of back-pressure
   always @(posedge clk)
   begin
      if (rst)
         output_read_en <= 1'b0;
      else
      begin
         if (output_read_en)
            check_pair(output_data);
         if (stall_left > 0)
            stall_left--;
         else if ($urandom_range(0, 31) == 0)
            stall_left = $urandom_range(10, 60);
         output_read_en <= !output_read_en && !output_empty && stall_left == 0;
      end
   end

   addr_pair: assert property (@(posedge clk) disable iff (rst)
      rq0_vld |-> rq1_vld && rq1_address == rq0_address + 1)
   else
   begin
      errors++;
      $display("ERROR addr_pair: expected %h actual %h",
               $sampled(rq0_address) + 1, $sampled(rq1_address));
   end

   // even word of a node that exists
   node_index: assert property (@(posedge clk) disable iff (rst)
      rq0_vld |-> !rq0_address[0] && (rq0_address >> 1) < 32)
   else
   begin
      errors++;
      $display("ERROR node_index: expected even address below 64 actual %h",
               $sampled(rq0_address));
   end

   lane_afull: assert property (@(posedge clk) disable iff (rst)
      (rq0_vld |-> !rq0_afull) and (rq1_vld |-> !rq1_afull))
   else
   begin
      errors++;
      $display("a memory lane got a request while its almost-full was high");
   end

   done_quiet: assert property (@(posedge clk) disable iff (rst)
      done |-> jobs_left == 0 && output_empty && !rs0_write_en && !rs1_write_en &&
               mem_lane0.pending == 0 && mem_lane1.pending == 0)
   else
   begin
      errors++;
      $display("done was high while work was still pending");
   end

   done_holds: assert property (@(posedge clk) disable iff (rst) done |=> done)
   else
   begin
      errors++;
      $display("done fell again after it had risen");
   end

   initial
   begin
      cycles = 0;
      while (cycles < timeout_cycles)
      begin
         @(posedge clk);
         cycles++;
      end
      errors++;
      $display("timeout: done did not rise within %0d cycles", timeout_cycles);
      finish_run();
   end

   initial
   begin
      void'($urandom(86));
      rst            = 1'b1;
      new_job_empty  = 1'b1;
      new_job        = '0;
      output_read_en = 1'b0;
      errors         = 0;
      reads          = 0;
      jobs_left      = 0;
      stall_left     = 0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      build_jobs();
      while (!(done && jobs_left == 0))
         @(posedge clk);
      // done must stay up for the rest of the run
      repeat (10) @(posedge clk);
      assert (expected.size() == 0)
      else
      begin
         errors++;
         $display("ERROR leftover: expected 0 pairs actual %0d", expected.size());
      end
      finish_run();
   end

endmodule

/* hdl/completion_monitor.sv */
module completion_monitor #(
   parameter int done_hold = 4
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          rq_strobe,
   input  logic                          rs0_write_en,
   input  logic                          rs1_write_en,
   input  logic                          new_job_empty,
   input  logic                          join_empty,
   input  logic                          rec_empty,
   input  logic                          output_empty,
   input  search_list_pkg::issue_state_e state,
   output logic                          done
);

   localparam int cnt_w = 16;
   localparam int run_w = $clog2(done_hold + 1);

   logic [cnt_w-1:0] pend0;
   logic [cnt_w-1:0] pend1;
   logic [run_w-1:0] run;
   logic             idle;

   // requests in flight per lane
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pend0 <= '0;
         pend1 <= '0;
      end
      else
      begin
         pend0 <= pend0 + cnt_w'(rq_strobe) - cnt_w'(rs0_write_en);
         pend1 <= pend1 + cnt_w'(rq_strobe) - cnt_w'(rs1_write_en);
      end
   end

   assign idle = new_job_empty && join_empty && rec_empty && output_empty &&
                 !rq_strobe && (pend0 == '0) && (pend1 == '0);

   // consecutive idle cycles, saturates at done_hold
   always_ff @(posedge clk)
   begin
      if (rst || !idle)
         run <= '0;
      else if (run != run_w'(done_hold))
         run <= run + 1'b1;
   end

   assign done = (run == run_w'(done_hold));

   no_underflow: assert property (@(posedge clk) disable iff (rst)
      (rs0_write_en |-> pend0 != '0) and (rs1_write_en |-> pend1 != '0));

   // issuer must have gone quiet before done
   done_means_idle: assert property (@(posedge clk) disable iff (rst)
      done |-> state == search_list_pkg::issue_idle);

endmodule

/* hdl/job_fifo.sv */
module job_fifo #(
   parameter int  fifo_depth  = 16,
   parameter int  afull_level = 12,
   parameter type payload_t   = search_list_pkg::job_t
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     write_en,
   input  payload_t write_data,
   output logic     afull,
   output logic     empty,
   input  logic     read_en,
   output payload_t read_data
);

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_w = $clog2(fifo_depth + 1);

   payload_t         mem [fifo_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;

   // storage array
   always_ff @(posedge clk)
   begin
      if (write_en)
         mem[wr_ptr] <= write_data;
   end

   // pointers wrap at the last slot
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (write_en)
            wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (read_en)
            rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
   end

   // occupancy
   always_ff @(posedge clk)
   begin
      if (rst)
         count <= '0;
      else if (write_en && !read_en)
         count <= count + 1'b1;
      else if (read_en && !write_en)
         count <= count - 1'b1;
   end

   // show-ahead head entry visible while not empty
   assign read_data = mem[rd_ptr];
   assign empty     = (count == '0);
   assign afull     = (count >= cnt_w'(afull_level));

   no_write_full: assert property (@(posedge clk) disable iff (rst)
      write_en |-> (count != cnt_w'(fifo_depth)));

   no_read_empty: assert property (@(posedge clk) disable iff (rst)
      read_en |-> !empty);

endmodule

/* hdl/node_decider.sv */
module node_decider #(
   parameter int fifo_depth  = 16,
   parameter int afull_level = 12
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   join_empty,
   input  search_list_pkg::join_t join_entry,
   output logic                   join_read_en,
   output logic                   rec_empty,
   output search_list_pkg::job_t  rec_job,
   input  logic                   rec_read_en,
   output logic                   output_empty,
   input  logic                   output_read_en,
   output search_list_pkg::match_t output_data
);

   logic                    hit;
   logic                    last;
   logic                    rec_afull;
   logic                    out_afull;
   logic                    rec_write_en;
   logic                    out_write_en;
   search_list_pkg::job_t   rec_in;
   search_list_pkg::match_t out_in;

   // upper halves decide the match
   assign hit  = (join_entry.node.dim_value[search_list_pkg::key_hi:search_list_pkg::key_lo] ==
                  join_entry.fact_value[search_list_pkg::key_hi:search_list_pkg::key_lo]);
   assign last = (join_entry.node.next_ptr == search_list_pkg::null_ptr);

   // each target stalls on its own almost-full
   assign out_write_en = !join_empty && hit && !out_afull;
   assign rec_write_en = !join_empty && !hit && !last && !rec_afull;
   // miss at the tail, drop without stalling
   assign join_read_en = out_write_en || rec_write_en || (!join_empty && !hit && last);

   // search moves on to the next node
   assign rec_in.fact_value = join_entry.fact_value;
   assign rec_in.ptr        = join_entry.node.next_ptr;

   assign out_in.dim_value  = join_entry.node.dim_value;
   assign out_in.fact_value = join_entry.fact_value;

   job_fifo #(.fifo_depth(fifo_depth), .afull_level(afull_level),
              .payload_t(search_list_pkg::job_t)) rec_q (
      .clk(clk), .rst(rst), .write_en(rec_write_en), .write_data(rec_in),
      .afull(rec_afull), .empty(rec_empty), .read_en(rec_read_en),
      .read_data(rec_job));

   job_fifo #(.fifo_depth(fifo_depth), .afull_level(afull_level),
              .payload_t(search_list_pkg::match_t)) out_q (
      .clk(clk), .rst(rst), .write_en(out_write_en), .write_data(out_in),
      .afull(out_afull), .empty(output_empty), .read_en(output_read_en),
      .read_data(output_data));

   one_target: assert property (@(posedge clk) disable iff (rst)
      !(rec_write_en && out_write_en));

endmodule

/* hdl/request_issuer.sv */
module request_issuer (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                new_job_empty,
   input  search_list_pkg::job_t               new_job,
   output logic                                new_job_read_en,
   input  logic                                rec_empty,
   input  search_list_pkg::job_t               rec_job,
   output logic                                rec_read_en,
   input  logic                                rq0_afull,
   input  logic                                rq1_afull,
   input  logic                                join_afull,
   output logic                                rq0_vld,
   output logic [search_list_pkg::addr_w-1:0]  rq0_address,
   output logic                                rq1_vld,
   output logic [search_list_pkg::addr_w-1:0]  rq1_address,
   output logic                                issue_strobe,
   output logic [search_list_pkg::data_w-1:0]  issue_fact,
   output search_list_pkg::issue_state_e       state
);

   search_list_pkg::issue_state_e     next_state;
   search_list_pkg::job_t             pick;
   logic                              new_valid;
   logic [search_list_pkg::addr_w-1:0] base;

   assign new_valid = (new_job.ptr != search_list_pkg::null_ptr);

   // recycled work first, then fresh jobs
   always_comb
   begin
      if (rq0_afull || rq1_afull || join_afull)
         next_state = search_list_pkg::issue_idle;
      else if (!rec_empty)
         next_state = search_list_pkg::issue_old;
      else if (!new_job_empty && new_valid)
         next_state = search_list_pkg::issue_new;
      else
         next_state = search_list_pkg::issue_idle;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= search_list_pkg::issue_idle;
      else
         state <= next_state;
   end

   // null pointers leave right away, even under back-pressure
   assign new_job_read_en = (!new_job_empty && !new_valid) ||
                            (next_state == search_list_pkg::issue_new);
   assign rec_read_en     = (next_state == search_list_pkg::issue_old);

   assign pick = (next_state == search_list_pkg::issue_old) ? rec_job : new_job;
   assign base = pick.ptr[search_list_pkg::addr_w-1:0];

   // node p lives at words 2p and 2p+1
   assign issue_strobe = (next_state != search_list_pkg::issue_idle);
   assign issue_fact   = pick.fact_value;
   assign rq0_vld      = issue_strobe;
   assign rq1_vld      = issue_strobe;
   assign rq0_address  = {base[search_list_pkg::addr_w-2:0], 1'b0};
   assign rq1_address  = {base[search_list_pkg::addr_w-2:0], 1'b1};

endmodule

/* hdl/response_join.sv */
module response_join #(
   parameter int fifo_depth  = 16,
   parameter int afull_level = 12
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                issue_strobe,
   input  logic [search_list_pkg::data_w-1:0]  issue_fact,
   input  logic                                rs0_write_en,
   input  logic [search_list_pkg::data_w-1:0]  rs0_data,
   input  logic                                rs1_write_en,
   input  logic [search_list_pkg::data_w-1:0]  rs1_data,
   output logic                                rs0_afull,
   output logic                                rs1_afull,
   output logic                                join_afull,
   output logic                                join_empty,
   input  logic                                join_read_en,
   output search_list_pkg::join_t              join_entry
);

   localparam int lead_w = $clog2(fifo_depth) + 2;

   logic fact_empty;
   logic dim_empty;
   logic next_empty;
   // facts issued minus responses seen, per lane
   logic [lead_w-1:0] lead0;
   logic [lead_w-1:0] lead1;

   // fact values wait here for their node
   job_fifo #(.fifo_depth(fifo_depth), .afull_level(afull_level),
              .payload_t(logic [search_list_pkg::data_w-1:0])) fact_q (
      .clk(clk), .rst(rst), .write_en(issue_strobe), .write_data(issue_fact),
      .afull(join_afull), .empty(fact_empty), .read_en(join_read_en),
      .read_data(join_entry.fact_value));

   // lane 0 returns dim values
   job_fifo #(.fifo_depth(fifo_depth), .afull_level(afull_level),
              .payload_t(logic [search_list_pkg::data_w-1:0])) dim_q (
      .clk(clk), .rst(rst), .write_en(rs0_write_en), .write_data(rs0_data),
      .afull(rs0_afull), .empty(dim_empty), .read_en(join_read_en),
      .read_data(join_entry.node.dim_value));

   // lane 1 returns next pointers
   job_fifo #(.fifo_depth(fifo_depth), .afull_level(afull_level),
              .payload_t(logic [search_list_pkg::data_w-1:0])) next_q (
      .clk(clk), .rst(rst), .write_en(rs1_write_en), .write_data(rs1_data),
      .afull(rs1_afull), .empty(next_empty), .read_en(join_read_en),
      .read_data(join_entry.node.next_ptr));

   // entry complete only once all three parts arrived
   assign join_empty = fact_empty || dim_empty || next_empty;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lead0 <= '0;
         lead1 <= '0;
      end
      else
      begin
         lead0 <= lead0 + lead_w'(issue_strobe) - lead_w'(rs0_write_en);
         lead1 <= lead1 + lead_w'(issue_strobe) - lead_w'(rs1_write_en);
      end
   end

   // a response never runs ahead of its fact
   rs_behind_fact: assert property (@(posedge clk) disable iff (rst)
      (rs0_write_en |-> lead0 != '0) and (rs1_write_en |-> lead1 != '0));

endmodule

/* hdl/search_list.sv */
module search_list #(
   parameter int fifo_depth  = 16,
   parameter int afull_level = 12,
   parameter int done_hold   = 4
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                new_job_empty,
   input  search_list_pkg::job_t               new_job,
   output logic                                new_job_read_en,
   output logic                                rq0_vld,
   output logic [search_list_pkg::addr_w-1:0]  rq0_address,
   input  logic                                rq0_afull,
   output logic                                rq1_vld,
   output logic [search_list_pkg::addr_w-1:0]  rq1_address,
   input  logic                                rq1_afull,
   input  logic                                rs0_write_en,
   input  logic [search_list_pkg::data_w-1:0]  rs0_data,
   output logic                                rs0_afull,
   input  logic                                rs1_write_en,
   input  logic [search_list_pkg::data_w-1:0]  rs1_data,
   output logic                                rs1_afull,
   output logic                                output_empty,
   input  logic                                output_read_en,
   output search_list_pkg::match_t             output_data,
   output logic                                done
);

   logic                               issue_strobe;
   logic [search_list_pkg::data_w-1:0] issue_fact;
   logic                               join_afull;
   logic                               join_empty;
   logic                               join_read_en;
   search_list_pkg::join_t             join_entry;
   logic                               rec_empty;
   logic                               rec_read_en;
   search_list_pkg::job_t              rec_job;
   search_list_pkg::issue_state_e      state;

   request_issuer issuer (
      .clk(clk), .rst(rst), .new_job_empty(new_job_empty), .new_job(new_job),
      .new_job_read_en(new_job_read_en), .rec_empty(rec_empty), .rec_job(rec_job),
      .rec_read_en(rec_read_en), .rq0_afull(rq0_afull), .rq1_afull(rq1_afull),
      .join_afull(join_afull), .rq0_vld(rq0_vld), .rq0_address(rq0_address),
      .rq1_vld(rq1_vld), .rq1_address(rq1_address), .issue_strobe(issue_strobe),
      .issue_fact(issue_fact), .state(state));

   // fact and both node words meet here
   response_join #(.fifo_depth(fifo_depth), .afull_level(afull_level)) joiner (
      .clk(clk), .rst(rst), .issue_strobe(issue_strobe), .issue_fact(issue_fact),
      .rs0_write_en(rs0_write_en), .rs0_data(rs0_data), .rs1_write_en(rs1_write_en),
      .rs1_data(rs1_data), .rs0_afull(rs0_afull), .rs1_afull(rs1_afull),
      .join_afull(join_afull), .join_empty(join_empty), .join_read_en(join_read_en),
      .join_entry(join_entry));

   node_decider #(.fifo_depth(fifo_depth), .afull_level(afull_level)) decider (
      .clk(clk), .rst(rst), .join_empty(join_empty), .join_entry(join_entry),
      .join_read_en(join_read_en), .rec_empty(rec_empty), .rec_job(rec_job),
      .rec_read_en(rec_read_en), .output_empty(output_empty),
      .output_read_en(output_read_en), .output_data(output_data));

   // both lanes strobe together, one strobe serves both counters
   completion_monitor #(.done_hold(done_hold)) monitor (
      .clk(clk), .rst(rst), .rq_strobe(issue_strobe), .rs0_write_en(rs0_write_en),
      .rs1_write_en(rs1_write_en), .new_job_empty(new_job_empty),
      .join_empty(join_empty), .rec_empty(rec_empty), .output_empty(output_empty),
      .state(state), .done(done));

endmodule

/* hdl/search_list_pkg.sv */
package search_list_pkg;

   // memory word, fact value and pointer width
   localparam int data_w = 64;
   // memory address width
   localparam int addr_w = 48;

   // invalid pointer, also marks the list tail
   localparam logic [data_w-1:0] null_ptr = '1;

   // compared key field, upper half of the word
   localparam int key_hi = 63;
   localparam int key_lo = 32;

   // new or recycled search job
   typedef struct packed {
      logic [data_w-1:0] fact_value;
      logic [data_w-1:0] ptr;
   } job_t;

   // both memory responses of one node
   typedef struct packed {
      logic [data_w-1:0] dim_value;
      logic [data_w-1:0] next_ptr;
   } node_t;

   // fact value aligned with its node
   typedef struct packed {
      logic [data_w-1:0] fact_value;
      node_t             node;
   } join_t;

   // result pair sent to the output queue
   typedef struct packed {
      logic [data_w-1:0] dim_value;
      logic [data_w-1:0] fact_value;
   } match_t;

   typedef enum logic [1:0] {
      issue_idle,
      issue_old,
      issue_new
   } issue_state_e;

endpackage

/* search_list.f */
hdl/search_list_pkg.sv
hdl/job_fifo.sv
hdl/response_join.sv
hdl/request_issuer.sv
hdl/node_decider.sv
hdl/completion_monitor.sv
hdl/search_list.sv
bench/list_memory_model.sv
bench/search_list_tb.sv
